/* design/vga_pkg.sv */
//////////////////////////////
// video bundle shared by all stages
// counters sized for frames up to 2047 pixels per side
// colour is 4 bits per channel, r in the top nibble
//////////////////////////////

`default_nettype none

package vga_pkg;

  localparam int CNT_W = 11;
  localparam int RGB_W = 12;

  // one pixel slot on its way down the video pipeline
  typedef struct packed {
    logic [CNT_W-1:0] hcount;
    logic [CNT_W-1:0] vcount;
    logic             hsync;  // active high
    logic             vsync;  // active high
    logic             hblnk;
    logic             vblnk;
    logic [RGB_W-1:0] rgb;
  } vga_sig_t;

endpackage

`default_nettype wire

/* design/game_pkg.sv */
//////////////////////////////
// maze layout, colours and the APB register map
// map is fixed at 16 by 12 tiles, column 0 in the MSB
// registers sit on word addresses 0x0, 0x4 and 0x8
//////////////////////////////

`default_nettype none

package game_pkg;

  localparam int MAZE_COLS = 16;
  localparam int MAZE_ROWS = 12;

  // one bit per tile, set means wall
  localparam logic [0:MAZE_ROWS-1][0:MAZE_COLS-1] MAZE_MAP = {
    16'b0000000000000000,
    16'b0110011001100110,
    16'b0100000000000010,
    16'b0001111001111000,
    16'b0000001001000000,
    16'b0111001001001110,
    16'b0100000000000010,
    16'b0101111001111010,
    16'b0000000000000000,
    16'b0110111001110110,
    16'b0000000000000000,
    16'b0000000000000000
  };

  localparam logic [vga_pkg::RGB_W-1:0] BLACK        = 12'h0_0_0;
  localparam logic [vga_pkg::RGB_W-1:0] PLAYER_RGB   = 12'h0_f_f;  // cyan
  localparam logic [vga_pkg::RGB_W-1:0] WALL_RGB_RST = 12'h0_0_f;  // blue

  localparam logic [3:0] ADDR_POS  = 4'h0;
  localparam logic [3:0] ADDR_WALL = 4'h4;
  localparam logic [3:0] ADDR_CTRL = 4'h8;

  typedef struct packed {
    logic [15:0] x;
    logic [15:0] y;
  } pos_t;

  typedef struct packed {
    logic [31-vga_pkg::RGB_W:0] pad;
    logic [vga_pkg::RGB_W-1:0]  rgb;
  } color_t;

  // APB data word, meaning depends on the address
  typedef union packed {
    pos_t   pos;
    color_t color;
  } reg_word_u;

endpackage

`default_nettype wire

/* design/vga_timing.sv */
//////////////////////////////
// free running VGA counters, all outputs registered
// sync pulses are active high
// line and frame totals must fit in vga_pkg::CNT_W bits
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vga_timing #(
  parameter int H_ACTIVE = 1024,
  parameter int H_FP     = 24,
  parameter int H_SYNC   = 136,
  parameter int H_BP     = 160,
  parameter int V_ACTIVE = 768,
  parameter int V_FP     = 3,
  parameter int V_SYNC   = 6,
  parameter int V_BP     = 29
) (
  input  wire logic             clk,
  input  wire logic             rst,
  output vga_pkg::vga_sig_t     vga_out
);

  localparam int W = vga_pkg::CNT_W;

  localparam logic [W-1:0] H_ACT = W'(H_ACTIVE);
  localparam logic [W-1:0] H_SS  = W'(H_ACTIVE + H_FP);
  localparam logic [W-1:0] H_SE  = W'(H_ACTIVE + H_FP + H_SYNC);
  localparam logic [W-1:0] H_END = W'(H_ACTIVE + H_FP + H_SYNC + H_BP - 1);
  localparam logic [W-1:0] V_ACT = W'(V_ACTIVE);
  localparam logic [W-1:0] V_SS  = W'(V_ACTIVE + V_FP);
  localparam logic [W-1:0] V_SE  = W'(V_ACTIVE + V_FP + V_SYNC);
  localparam logic [W-1:0] V_END = W'(V_ACTIVE + V_FP + V_SYNC + V_BP - 1);

  logic [W-1:0] h_nxt;
  logic [W-1:0] v_nxt;

  always_comb begin
    h_nxt = vga_out.hcount + 1'b1;
    v_nxt = vga_out.vcount;
    if (vga_out.hcount == H_END) begin
      h_nxt = '0;
      v_nxt = (vga_out.vcount == V_END) ? '0 : vga_out.vcount + 1'b1;  // end of line
    end
  end

  // flags come from the next count so they line up with it
  always_ff @(posedge clk) begin
    if (rst) begin
      vga_out <= '0;
    end else begin
      vga_out.hcount <= h_nxt;
      vga_out.vcount <= v_nxt;
      vga_out.hblnk  <= (h_nxt >= H_ACT);
      vga_out.vblnk  <= (v_nxt >= V_ACT);
      vga_out.hsync  <= (h_nxt >= H_SS) && (h_nxt < H_SE);
      vga_out.vsync  <= (v_nxt >= V_SS) && (v_nxt < V_SE);
      vga_out.rgb    <= '0;  // colour is added downstream
    end
  end

endmodule

`default_nettype wire

/* design/apb_regs.sv */
//////////////////////////////
// APB slave with three registers, no wait states
// unknown addresses answer with pslverr and zero data
// only paddr[3:0] is decoded
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module apb_regs (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              psel,
  input  wire logic              penable,
  input  wire logic              pwrite,
  input  wire logic [3:0]        paddr,
  input  wire logic [31:0]       pwdata,
  output logic      [31:0]       prdata,
  output logic                   pready,
  output logic                   pslverr,
  output game_pkg::pos_t         player_pos,
  output logic [vga_pkg::RGB_W-1:0] wall_rgb,
  output logic                   player_en
);

  logic                access;
  logic                addr_ok;
  game_pkg::reg_word_u wdata;
  game_pkg::reg_word_u rdata;

  assign access = psel && penable;
  assign wdata  = pwdata;

  always_comb begin
    rdata   = '0;
    addr_ok = 1'b1;
    case (paddr)
      game_pkg::ADDR_POS:  rdata.pos = player_pos;
      game_pkg::ADDR_WALL: rdata.color.rgb = wall_rgb;
      game_pkg::ADDR_CTRL: rdata[0] = player_en;
      default:             addr_ok = 1'b0;
    endcase
  end

  // every access finishes in its first cycle
  assign pready  = access;
  assign pslverr = access && !addr_ok;
  assign prdata  = (access && !pwrite) ? rdata : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      player_pos <= '0;
      wall_rgb   <= game_pkg::WALL_RGB_RST;
      player_en  <= 1'b0;
    end else if (access && pwrite) begin
      case (paddr)
        game_pkg::ADDR_POS:  player_pos <= wdata.pos;
        game_pkg::ADDR_WALL: wall_rgb   <= wdata.color.rgb;
        game_pkg::ADDR_CTRL: player_en  <= pwdata[0];
        default: ;  // write dropped, error flagged above
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/draw_bg.sv */
//////////////////////////////
// maze background, one cycle latency
// H_ACTIVE and V_ACTIVE must equal the map size
// times the tile edge of 1 << TILE_SHIFT
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module draw_bg #(
  parameter int H_ACTIVE   = 1024,
  parameter int V_ACTIVE   = 768,
  parameter int TILE_SHIFT = 6
) (
  input  wire logic                     clk,
  input  wire logic                     rst,
  input  wire vga_pkg::vga_sig_t        vga_in,
  input  wire logic [vga_pkg::RGB_W-1:0] wall_rgb,
  output vga_pkg::vga_sig_t             vga_out
);

  localparam int W     = vga_pkg::CNT_W;
  localparam int COL_W = $clog2(game_pkg::MAZE_COLS);
  localparam int ROW_W = $clog2(game_pkg::MAZE_ROWS);

  localparam logic [W-1:0] H_LAST = W'(H_ACTIVE - 1);
  localparam logic [W-1:0] V_LAST = W'(V_ACTIVE - 1);

  logic [COL_W-1:0]    tile_col;
  logic [ROW_W-1:0]    tile_row;
  logic                edge_px;
  logic                wall_px;
  vga_pkg::vga_sig_t   vga_nxt;

  // tile index, only meaningful inside the active area
  assign tile_col = COL_W'(vga_in.hcount >> TILE_SHIFT);
  assign tile_row = ROW_W'(vga_in.vcount >> TILE_SHIFT);

  assign edge_px = (vga_in.hcount == '0) || (vga_in.hcount == H_LAST) ||
                   (vga_in.vcount == '0) || (vga_in.vcount == V_LAST);

  always_comb begin
    vga_nxt = vga_in;
    wall_px = 1'b0;
    if (vga_in.hblnk || vga_in.vblnk) begin
      vga_nxt.rgb = game_pkg::BLACK;
    end else if (edge_px) begin
      vga_nxt.rgb = wall_rgb;  // frame border
    end else begin
      wall_px     = game_pkg::MAZE_MAP[tile_row][tile_col];
      vga_nxt.rgb = wall_px ? wall_rgb : game_pkg::BLACK;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vga_out <= '0;
    end else begin
      vga_out <= vga_nxt;
    end
  end

endmodule

`default_nettype wire

/* design/draw_player.sv */
//////////////////////////////
// player square overlay, one cycle latency
// position and enable apply from the next frame start
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module draw_player #(
  parameter int TILE_SHIFT = 6
) (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire vga_pkg::vga_sig_t vga_in,
  input  wire game_pkg::pos_t    player_pos,
  input  wire logic              player_en,
  output vga_pkg::vga_sig_t      vga_out
);

  localparam logic [16:0] TILE = 17'(1 << TILE_SHIFT);

  game_pkg::pos_t    pos_q;
  logic              en_q;
  game_pkg::pos_t    pos_use;
  logic              en_use;
  logic              sof;
  logic [16:0]       hc;
  logic [16:0]       vc;
  logic              in_sq;
  vga_pkg::vga_sig_t vga_nxt;

  assign sof = (vga_in.hcount == '0) && (vga_in.vcount == '0);

  // the frame's first pixel already sees the new values
  assign pos_use = sof ? player_pos : pos_q;
  assign en_use  = sof ? player_en : en_q;

  assign hc = 17'(vga_in.hcount);
  assign vc = 17'(vga_in.vcount);

  assign in_sq = (hc >= {1'b0, pos_use.x}) && (hc < {1'b0, pos_use.x} + TILE) &&
                 (vc >= {1'b0, pos_use.y}) && (vc < {1'b0, pos_use.y} + TILE);

  always_comb begin
    vga_nxt = vga_in;
    if (en_use && !vga_in.hblnk && !vga_in.vblnk && in_sq)
      vga_nxt.rgb = game_pkg::PLAYER_RGB;  // drawn over walls too
  end

  always_ff @(posedge clk) begin
    if (sof)
      pos_q <= player_pos;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      en_q    <= 1'b0;
      vga_out <= '0;
    end else begin
      if (sof)
        en_q <= player_en;
      vga_out <= vga_nxt;
    end
  end

endmodule

`default_nettype wire

/* design/maze_top.sv */
//////////////////////////////
// maze screen top, APB in, VGA bundle out
// vga_out lags the counters by two cycles
// defaults are 1024x768 with 64 pixel tiles
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module maze_top #(
  parameter int H_ACTIVE   = 1024,
  parameter int H_FP       = 24,
  parameter int H_SYNC     = 136,
  parameter int H_BP       = 160,
  parameter int V_ACTIVE   = 768,
  parameter int V_FP       = 3,
  parameter int V_SYNC     = 6,
  parameter int V_BP       = 29,
  parameter int TILE_SHIFT = 6
) (
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire logic        psel,
  input  wire logic        penable,
  input  wire logic        pwrite,
  input  wire logic [3:0]  paddr,
  input  wire logic [31:0] pwdata,
  output logic      [31:0] prdata,
  output logic             pready,
  output logic             pslverr,
  output vga_pkg::vga_sig_t vga_out
);

  vga_pkg::vga_sig_t           vga_tim;
  vga_pkg::vga_sig_t           vga_bg;
  game_pkg::pos_t              player_pos;
  logic [vga_pkg::RGB_W-1:0]   wall_rgb;
  logic                        player_en;

  vga_timing #(
    .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
    .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
  ) u_timing (
    .clk(clk), .rst(rst), .vga_out(vga_tim)
  );

  apb_regs u_regs (
    .clk(clk), .rst(rst),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .player_pos(player_pos), .wall_rgb(wall_rgb), .player_en(player_en)
  );

  draw_bg #(
    .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .TILE_SHIFT(TILE_SHIFT)
  ) u_bg (
    .clk(clk), .rst(rst), .vga_in(vga_tim), .wall_rgb(wall_rgb), .vga_out(vga_bg)
  );

  draw_player #(
    .TILE_SHIFT(TILE_SHIFT)
  ) u_player (
    .clk(clk), .rst(rst), .vga_in(vga_bg),
    .player_pos(player_pos), .player_en(player_en), .vga_out(vga_out)
  );

endmodule

`default_nettype wire

/* bench/maze_assertions.sv */
//////////////////////////////
// bound to maze_top
// reports only through failing assertions
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module maze_assertions #(
  parameter int H_ACTIVE = 1024
) (
  input wire logic              clk,
  input wire logic              rst,
  input wire logic              psel,
  input wire logic              penable,
  input wire logic              pready,
  input wire logic              pslverr,
  input wire vga_pkg::vga_sig_t vga_out
);

  // APB responses only in the access cycle
  a_apb_resp: assert property (@(posedge clk) disable iff (rst)
    !(psel && penable) |-> (!pready && !pslverr))
    else $error("pready or pslverr high outside an access cycle");

  a_blank_black: assert property (@(posedge clk) disable iff (rst)
    (vga_out.hblnk || vga_out.vblnk) |-> (vga_out.rgb == '0))
    else $error("rgb not zero while blanking");

  a_hsync_active: assert property (@(posedge clk) disable iff (rst)
    (vga_out.hcount < H_ACTIVE) |-> !vga_out.hsync)
    else $error("hsync high inside the active area");

endmodule

bind maze_top maze_assertions #(.H_ACTIVE(H_ACTIVE)) u_assert (
  .clk(clk), .rst(rst), .psel(psel), .penable(penable),
  .pready(pready), .pslverr(pslverr), .vga_out(vga_out)
);

`default_nettype wire

/* bench/maze_tb.sv */
//////////////////////////////
// runs a 64x48 frame with 4 pixel tiles
// one frame is 80x54 = 4320 clocks
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module maze_tb;

  localparam int H_ACT = 64;
  localparam int V_ACT = 48;
  localparam int H_TOT = 80;
  localparam int TILE = 4;
  localparam int FRAME = 4320;
  localparam int N_ENT = 7;
  localparam longint WATCHDOG_NS = longint'(N_ENT + 2) * 2 * FRAME * 4;

  typedef struct packed {
    logic              rel;  // offset from the player position
    logic signed [7:0] x;
    logic signed [7:0] y;
  } probe_t;

  typedef struct packed {
    logic [1:0]       op;  // 0 none, 1 write, 2 write mid frame
    logic [3:0]       addr;
    logic [31:0]      data;
    probe_t [3:0]     probes;
  } entry_t;

  logic clk, rst, psel, penable, pwrite;
  logic [3:0] paddr;
  logic [31:0] pwdata, prdata;
  logic pready, pslverr;
  vga_pkg::vga_sig_t vga_out;

  entry_t table_e [N_ENT];
  logic [15:0] maze_rows [12] = '{
    16'b0000000000000000, 16'b0110011001100110, 16'b0100000000000010,
    16'b0001111001111000, 16'b0000001001000000, 16'b0111001001001110,
    16'b0100000000000010, 16'b0101111001111010, 16'b0000000000000000,
    16'b0110111001110110, 16'b0000000000000000, 16'b0000000000000000
  };
  int errors = 0;
  int m_x, m_y, n_x, n_y;
  logic [11:0] m_wall, n_wall;
  logic m_en, n_en;
  int px [4];
  int py [4];

  maze_top #(
    .H_ACTIVE(64), .H_FP(4), .H_SYNC(8), .H_BP(4),
    .V_ACTIVE(48), .V_FP(2), .V_SYNC(2), .V_BP(2), .TILE_SHIFT(2)
  ) dut0 (
    .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .pslverr(pslverr), .vga_out(vga_out)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish in time");
    $display("Checks failed");
    $finish;
  end

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic apb_xfer(input logic wr, input logic [3:0] a, input logic [31:0] d,
                          output logic [31:0] rd, output logic err, output logic rdy);
    @(posedge clk);
    psel <= 1'b1;
    penable <= 1'b0;
    pwrite <= wr;
    paddr <= a;
    pwdata <= d;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    rd = prdata;
    err = pslverr;
    rdy = pready;
    @(posedge clk);
    psel <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_check(input logic wr, input logic [3:0] a, input logic [31:0] d,
                           input logic [31:0] exp_rd, input logic exp_err);
    logic [31:0] rd;
    logic err;
    logic rdy;
    apb_xfer(wr, a, d, rd, err, rdy);
    if (rdy !== 1'b1) check_val("pready", 64'(rdy), 64'h1);
    if (!wr) check_val("prdata", rd, exp_rd);
    check_val("pslverr", 32'(err), 32'(exp_err));
  endtask

  function automatic logic [11:0] expected_rgb(int x, int y);
    logic [11:0] c;
    c = 12'h000;
    if (x < H_ACT && y < V_ACT) begin
      if (x == 0 || x == H_ACT - 1 || y == 0 || y == V_ACT - 1) c = m_wall;
      else if (maze_rows[y / TILE][15 - x / TILE]) c = m_wall;
      if (m_en && x >= m_x && x < m_x + TILE && y >= m_y && y < m_y + TILE)
        c = 12'h0ff;  // player over anything
    end
    return c;
  endfunction

  function automatic logic at_sof();
    return (vga_out.hcount == '0) && (vga_out.vcount == '0);
  endfunction

  task automatic check_pixel(input int n);
    int hc, vc;
    hc = int'(vga_out.hcount);
    vc = int'(vga_out.vcount);
    if (hc != n % H_TOT) check_val("hcount", 64'(hc), 64'(n % H_TOT));
    if (vc != n / H_TOT) check_val("vcount", 64'(vc), 64'(n / H_TOT));
    if (vga_out.hblnk !== (hc >= 64)) check_val("hblnk", 32'(vga_out.hblnk), 32'(hc >= 64));
    if (vga_out.vblnk !== (vc >= 48)) check_val("vblnk", 32'(vga_out.vblnk), 32'(vc >= 48));
    if (vga_out.hsync !== (hc >= 68 && hc < 76))
      check_val("hsync", 32'(vga_out.hsync), 32'(hc >= 68 && hc < 76));
    if (vga_out.vsync !== (vc >= 50 && vc < 52))
      check_val("vsync", 32'(vga_out.vsync), 32'(vc >= 50 && vc < 52));
    if ((vga_out.hblnk || vga_out.vblnk) && vga_out.rgb !== 12'h000)
      check_val("rgb", 32'(vga_out.rgb), 32'h0);
    for (int i = 0; i < 4; i++) begin
      if (hc == px[i] && vc == py[i])
        check_val("rgb", 32'(vga_out.rgb), 32'(expected_rgb(hc, vc)));
    end
  endtask

  // caller sits at a falling edge, stops at the next frame start
  task automatic scan_frame();
    int n;
    n = int'(vga_out.vcount) * H_TOT + int'(vga_out.hcount);
    do begin
      check_pixel(n);
      n++;
      @(negedge clk);
    end while (!at_sof());
    if (n != FRAME) check_val("frame length", 64'(n), 64'(FRAME));
  endtask

  task automatic wait_sof();
    do @(negedge clk); while (!at_sof());
  endtask

  function automatic int clamp(int v, int hi);
    return (v < 0) ? 0 : (v > hi) ? hi : v;
  endfunction

  task automatic build_table();
    int ax, ay, ux, uy;
    probe_t [3:0] fixed_p, rel_p;
    ax = ($urandom % 16) * TILE;
    ay = ($urandom % 12) * TILE;
    ux = $urandom % 61;
    uy = $urandom % 45;
    fixed_p = {{1'b0, 8'sd0, 8'sd0}, {1'b0, 8'sd63, 8'sd20},
               {1'b0, 8'sd5, 8'sd5}, {1'b0, 8'sd2, 8'sd2}};
    rel_p = {{1'b1, 8'sd0, 8'sd0}, {1'b1, 8'sd3, 8'sd3},
             {1'b1, 8'sd4, 8'sd0}, {1'b1, -8'sd1, 8'sd3}};
    table_e[0] = {2'd0, 4'h0, 32'h0, fixed_p};
    table_e[1] = {2'd1, 4'h4, 32'($urandom % 4096), fixed_p};
    table_e[2] = {2'd1, 4'h0, 16'(ax), 16'(ay), rel_p};
    table_e[3] = {2'd1, 4'h8, 32'h1, rel_p};
    table_e[4] = {2'd1, 4'h0, 16'(ux), 16'(uy), rel_p};
    table_e[5] = {2'd2, 4'h0, 16'd8, 16'd36, rel_p};  // below the write row
    table_e[6] = {2'd1, 4'h8, 32'h0, rel_p};
  endtask

  task automatic run_entry(input entry_t e);
    n_x = m_x;
    n_y = m_y;
    n_wall = m_wall;
    n_en = m_en;
    if (e.op != 2'd0) begin
      case (e.addr)
        4'h0: begin
          n_x = int'(e.data[31:16]);
          n_y = int'(e.data[15:0]);
        end
        4'h4: n_wall = e.data[11:0];
        default: n_en = e.data[0];
      endcase
    end
    for (int i = 0; i < 4; i++) begin
      px[i] = clamp(int'($signed(e.probes[i].x)) + (e.probes[i].rel ? n_x : 0), H_ACT - 1);
      py[i] = clamp(int'($signed(e.probes[i].y)) + (e.probes[i].rel ? n_y : 0), V_ACT - 1);
    end
    if (e.op == 2'd2) begin
      wait_sof();
      do @(negedge clk); while (vga_out.vcount != 11'd20);
      apb_check(1'b1, e.addr, e.data, 32'h0, 1'b0);
      @(negedge clk);
      scan_frame();  // rest of this frame keeps the old position
    end else if (e.op == 2'd1) begin
      apb_check(1'b1, e.addr, e.data, 32'h0, 1'b0);
      @(posedge clk);
    end
    m_x = n_x;
    m_y = n_y;
    m_wall = n_wall;
    m_en = n_en;
    if (e.op != 2'd2) wait_sof();
    scan_frame();
  endtask

  initial begin
    void'($urandom(32'h6f5b));
    rst = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = 4'h0;
    pwdata = 32'h0;
    repeat (15) @(posedge clk);
    @(negedge clk);
    check_val("vga_out", 64'(vga_out), 64'h0);
    @(posedge clk);
    rst <= 1'b0;
    apb_check(1'b0, 4'h0, 32'h0, 32'h0, 1'b0);
    apb_check(1'b0, 4'h4, 32'h0, 32'h00f, 1'b0);
    apb_check(1'b0, 4'h8, 32'h0, 32'h0, 1'b0);
    apb_check(1'b1, 4'h0, 32'h0012_0034, 32'h0, 1'b0);
    apb_check(1'b0, 4'h0, 32'h0, 32'h0012_0034, 1'b0);
    apb_check(1'b1, 4'h4, 32'h0000_0abc, 32'h0, 1'b0);
    apb_check(1'b0, 4'h4, 32'h0, 32'h0000_0abc, 1'b0);
    apb_check(1'b1, 4'h8, 32'h1, 32'h0, 1'b0);
    apb_check(1'b0, 4'h8, 32'h0, 32'h1, 1'b0);
    apb_check(1'b1, 4'h8, 32'h0, 32'h0, 1'b0);
    apb_check(1'b1, 4'h4, 32'h00f, 32'h0, 1'b0);
    apb_check(1'b1, 4'hc, 32'hffff_ffff, 32'h0, 1'b1);
    apb_check(1'b0, 4'hc, 32'h0, 32'h0, 1'b1);
    m_x = 'h12;
    m_y = 'h34;
    m_wall = 12'h00f;
    m_en = 1'b0;
    build_table();
    for (int i = 0; i < N_ENT; i++) run_entry(table_e[i]);
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
design/vga_pkg.sv
design/game_pkg.sv
design/vga_timing.sv
design/apb_regs.sv
design/draw_bg.sv
design/draw_player.sv
design/maze_top.sv
bench/maze_assertions.sv
bench/maze_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := maze_tb
FILELIST  := src.f
OBJDIR    := obj_dir
LOG       := sim.log

SIM  := $(OBJDIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	@$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Checks failed" $(LOG); then \
	  echo "simulation FAILED"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
